/* Makefile */
TOP := tb_pbch_dmrs_detect

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) --Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+.
pbch_pkg.sv
dmrs_table_if.sv
pn_lfsr.sv
dmrs_generator.sv
dmrs_table.sv
dmrs_correlator.sv
ibar_selector.sv
pbch_dmrs_detect_top.sv
pbch_dmrs_detect_sva.sv
tb_clock_gen.sv
tb_pbch_dmrs_detect.sv

/* dmrs_correlator.sv */
`timescale 1ns/1ps
`include "pbch_consts.svh"

module dmrs_correlator (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic                s_valid_i,
    input  pbch_pkg::sample_t   s_data_i,
    input  logic                pbch_start_i,
    input  logic                dmrs_ready_i,
    input  logic [1:0]          start_idx_i,
    output pbch_pkg::corr_vec_t corr_o,
    output pbch_pkg::corr_vec_t corr_rot_o,
    output logic                corr_done_o,
    dmrs_table_if.corr          tbl
);
    import pbch_pkg::*;

    localparam int SC_W = $clog2(`PBCH_FFT_LEN);

    logic            busy_q;
    logic            last_q;
    logic            acc_en_q;
    logic [SC_W-1:0] sc_cnt_q;
    logic [SC_W-1:0] sc_rel;
    logic [1:0]      start_q;
    dmrs_addr_t      pilot_idx_q;
    dmrs_sym_t       rx_q;
    dmrs_sym_t       rx_rot_q;
    logic            accept;
    logic            take;
    logic            is_pilot;

    // each bit adds +1 on a match and -1 on a mismatch
    function automatic corr_t pair_score(dmrs_sym_t ref_sym, dmrs_sym_t rx_sym);
        corr_t score;
        score = (ref_sym[1] == rx_sym[1]) ? corr_t'(1) : corr_t'(-1);
        score = score + ((ref_sym[0] == rx_sym[0]) ? corr_t'(1) : corr_t'(-1));
        return score;
    endfunction

    // the accumulators must stay stable until the selector has sampled them
    assign accept = pbch_start_i && dmrs_ready_i && !busy_q && !last_q;
    assign take   = s_valid_i && busy_q;

    assign sc_rel   = sc_cnt_q - SC_W'(start_q);
    assign is_pilot = (sc_rel % `PBCH_PILOT_SPACING) == 0;

    assign tbl.rd_addr = pilot_idx_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q      <= 1'b0;
            last_q      <= 1'b0;
            acc_en_q    <= 1'b0;
            corr_done_o <= 1'b0;
            sc_cnt_q    <= '0;
            start_q     <= '0;
            pilot_idx_q <= '0;
        end else begin
            acc_en_q    <= take && is_pilot;
            last_q      <= take && (sc_cnt_q == SC_W'(`PBCH_FFT_LEN - 1));
            corr_done_o <= last_q;
            if (accept) begin
                busy_q      <= 1'b1;
                sc_cnt_q    <= '0;
                pilot_idx_q <= '0;
                start_q     <= start_idx_i;
            end else if (take) begin
                sc_cnt_q <= sc_cnt_q + 1'b1;
                if (is_pilot) begin
                    pilot_idx_q <= pilot_idx_q + 1'b1;
                end
                if (sc_cnt_q == SC_W'(`PBCH_FFT_LEN - 1)) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // hard demodulation, the rotated pair undoes a 90 degree phase step
    always_ff @(posedge clk_i) begin
        rx_q     <= {s_data_i.re[$bits(s_data_i.re)-1], s_data_i.im[$bits(s_data_i.im)-1]};
        rx_rot_q <= {~s_data_i.im[$bits(s_data_i.im)-1], s_data_i.re[$bits(s_data_i.re)-1]};
    end

    // rd_row and the demodulated pair line up one cycle after the sample
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            if (accept) begin
                corr_o[i]     <= '0;
                corr_rot_o[i] <= '0;
            end else if (acc_en_q) begin
                corr_o[i]     <= corr_o[i] + pair_score(tbl.rd_row[i], rx_q);
                corr_rot_o[i] <= corr_rot_o[i] + pair_score(tbl.rd_row[i], rx_rot_q);
            end
        end
    end

endmodule

/* dmrs_generator.sv */
`timescale 1ns/1ps
`include "pbch_consts.svh"

module dmrs_generator (
    input  logic            clk_i,
    input  logic            reset_ni,
    input  pbch_pkg::n_id_t n_id_i,
    input  logic            n_id_valid_i,
    output logic            dmrs_ready_o,
    output logic [1:0]      start_idx_o,
    dmrs_table_if.gen       tbl
);
    import pbch_pkg::*;

    localparam int LW = `PBCH_LFSR_LEN;
    localparam int CNT_W = $clog2(`PBCH_SKIP_BITS);

    // x1 uses x(n+3) ^ x(n), x2 uses x(n+3) ^ x(n+2) ^ x(n+1) ^ x(n)
    localparam logic [LW-1:0] X1_TAPS = 'h9;
    localparam logic [LW-1:0] X2_TAPS = 'hf;

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_LOAD,
        GEN_SKIP,
        GEN_EMIT
    } gen_state_t;

    gen_state_t                      state_q;
    logic [CNT_W-1:0]                cnt_q;
    n_id_t                           n_id_q;
    logic                            lfsr_load;
    logic                            lfsr_step;
    logic                            x1_bit;
    logic [`PBCH_NUM_IBAR-1:0]       c_bits;
    logic [`PBCH_NUM_IBAR-1:0]       hold_q;

    assign lfsr_load = (state_q == GEN_LOAD);
    assign lfsr_step = (state_q == GEN_SKIP) || (state_q == GEN_EMIT);

    pn_lfsr #(.TAPS(X1_TAPS)) x1_lfsr_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .load_i   (lfsr_load),
        .step_i   (lfsr_step),
        .seed_i   (LW'(1)),
        .bit_o    (x1_bit)
    );

    for (genvar i = 0; i < `PBCH_NUM_IBAR; i++) begin : g_cand
        logic [LW-1:0] c_init;
        logic          x2_bit;

        // c_init = 2^11 (i+1)(N_id/4+1) + 2^6 (i+1) + N_id mod 4
        assign c_init = ((LW'(i + 1) * (LW'(n_id_q[9:2]) + LW'(1))) << 11)
                      + (LW'(i + 1) << 6)
                      + LW'(n_id_q[1:0]);

        pn_lfsr #(.TAPS(X2_TAPS)) x2_lfsr_i (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .load_i   (lfsr_load),
            .step_i   (lfsr_step),
            .seed_i   (c_init),
            .bit_o    (x2_bit)
        );

        assign c_bits[i] = x1_bit ^ x2_bit;
    end

    // a new cell identity restarts the sequence from any state
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= GEN_IDLE;
            cnt_q        <= '0;
            n_id_q       <= '0;
            dmrs_ready_o <= 1'b0;
        end else if (n_id_valid_i) begin
            state_q      <= GEN_LOAD;
            n_id_q       <= n_id_i;
            dmrs_ready_o <= 1'b0;
        end else begin
            case (state_q)
                GEN_LOAD: begin
                    cnt_q   <= '0;
                    state_q <= GEN_SKIP;
                end
                GEN_SKIP: begin
                    if (cnt_q == CNT_W'(`PBCH_SKIP_BITS - 1)) begin
                        cnt_q   <= '0;
                        state_q <= GEN_EMIT;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                GEN_EMIT: begin
                    if (cnt_q == CNT_W'(2 * `PBCH_DMRS_LEN - 1)) begin
                        state_q      <= GEN_IDLE;
                        dmrs_ready_o <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // even output bits wait here for their odd partner
    always_ff @(posedge clk_i) begin
        if (state_q == GEN_EMIT && !cnt_q[0]) begin
            hold_q <= c_bits;
        end
    end

    assign tbl.wr_en   = (state_q == GEN_EMIT) && cnt_q[0];
    assign tbl.wr_addr = dmrs_addr_t'(cnt_q >> 1);

    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            tbl.wr_row[i] = {hold_q[i], c_bits[i]};
        end
    end

    assign start_idx_o = n_id_q[1:0];

endmodule

/* dmrs_table.sv */
`timescale 1ns/1ps
`include "pbch_consts.svh"

module dmrs_table (
    input  logic      clk_i,
    dmrs_table_if.mem tbl
);
    import pbch_pkg::*;

    // row k holds symbol k of all eight candidates
    dmrs_row_t mem_q [`PBCH_DMRS_LEN];

    always_ff @(posedge clk_i) begin
        if (tbl.wr_en) begin
            mem_q[tbl.wr_addr] <= tbl.wr_row;
        end
    end

    // registered read, the row follows the address by one cycle
    always_ff @(posedge clk_i) begin
        tbl.rd_row <= mem_q[tbl.rd_addr];
    end

endmodule

/* dmrs_table_if.sv */
`timescale 1ns/1ps

interface dmrs_table_if;
    import pbch_pkg::*;

    // write side, one full row per write
    logic       wr_en;
    dmrs_addr_t wr_addr;
    dmrs_row_t  wr_row;

    // read side, data follows the address by one cycle
    dmrs_addr_t rd_addr;
    dmrs_row_t  rd_row;

    modport gen (
        output wr_en,
        output wr_addr,
        output wr_row
    );

    modport corr (
        output rd_addr,
        input  rd_row
    );

    modport mem (
        input  wr_en,
        input  wr_addr,
        input  wr_row,
        input  rd_addr,
        output rd_row
    );

endinterface

/* ibar_selector.sv */
`timescale 1ns/1ps
`include "pbch_consts.svh"

module ibar_selector (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  pbch_pkg::corr_vec_t corr_i,
    input  pbch_pkg::corr_vec_t corr_rot_i,
    input  logic                corr_done_i,
    output pbch_pkg::ibar_t     ibar_o,
    output logic                ibar_valid_o
);
    import pbch_pkg::*;

    typedef logic [7:0] mag_t;

    mag_t  score [`PBCH_NUM_IBAR];
    mag_t  best_score;
    ibar_t best_idx;

    // |-128| is 128, which still fits eight unsigned bits
    function automatic mag_t corr_abs(corr_t value);
        corr_t negated;
        negated = -value;
        return value[$bits(corr_t)-1] ? mag_t'(negated) : mag_t'(value);
    endfunction

    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            score[i] = (corr_abs(corr_i[i]) > corr_abs(corr_rot_i[i])) ?
                       corr_abs(corr_i[i]) : corr_abs(corr_rot_i[i]);
        end
        best_score = score[0];
        best_idx   = '0;
        // strict compare keeps the lowest index on a tie
        for (int i = 1; i < `PBCH_NUM_IBAR; i++) begin
            if (score[i] > best_score) begin
                best_score = score[i];
                best_idx   = ibar_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ibar_o       <= '0;
            ibar_valid_o <= 1'b0;
        end else begin
            ibar_valid_o <= corr_done_i;
            if (corr_done_i) begin
                ibar_o <= best_idx;
            end
        end
    end

endmodule

/* pbch_consts.svh */
`ifndef PBCH_CONSTS_SVH
`define PBCH_CONSTS_SVH

// length of both Gold sequence LFSRs
`define PBCH_LFSR_LEN 31

// bits dropped from the Gold sequence before the first DMRS bit
`define PBCH_SKIP_BITS 1600

// QPSK symbols per PBCH DMRS candidate
`define PBCH_DMRS_LEN 144

// one candidate per SSB index ibar
`define PBCH_NUM_IBAR 8

// subcarriers in one PBCH symbol
`define PBCH_FFT_LEN 256

// a pilot sits on every fourth subcarrier
`define PBCH_PILOT_SPACING 4

// complex sample with 16 bit I in the low half and 16 bit Q in the high half
`define PBCH_SAMPLE_DW 32

`endif

/* pbch_dmrs_detect_sva.sv */
`timescale 1ns/1ps

module pbch_dmrs_detect_sva (
    input logic            clk_i,
    input logic            reset_ni,
    input logic            n_id_valid_i,
    input logic            dmrs_ready_i,
    input logic            ibar_valid_i,
    input pbch_pkg::ibar_t ibar_i
);

    logic pulse_fail   = 1'b0;
    logic ready_fail   = 1'b0;
    logic unknown_fail = 1'b0;
    logic any_fail;

    assign any_fail = pulse_fail | ready_fail | unknown_fail;

    // a result is announced by a single cycle strobe
    ibar_valid_pulse: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_i |=> !ibar_valid_i
    ) else begin
        pulse_fail = 1'b1;
        $error("ibar_valid_o stayed high for two cycles");
    end

    // a new cell identity invalidates the stored candidates at once
    ready_drop: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !dmrs_ready_i
    ) else begin
        ready_fail = 1'b1;
        $error("dmrs_ready_o still high after n_id_valid_i");
    end

    outputs_known: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        !$isunknown({dmrs_ready_i, ibar_valid_i, ibar_i})
    ) else begin
        unknown_fail = 1'b1;
        $error("an output of the detector is unknown");
    end

endmodule

bind pbch_dmrs_detect_top pbch_dmrs_detect_sva pbch_dmrs_detect_sva_i (
    .clk_i        (clk_i),
    .reset_ni     (reset_ni),
    .n_id_valid_i (n_id_valid_i),
    .dmrs_ready_i (dmrs_ready_o),
    .ibar_valid_i (ibar_valid_o),
    .ibar_i       (ibar_o)
);

/* pbch_dmrs_detect_top.sv */
`timescale 1ns/1ps
`include "pbch_consts.svh"

module pbch_dmrs_detect_top (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  pbch_pkg::n_id_t            n_id_i,
    input  logic                       n_id_valid_i,
    input  logic                       pbch_start_i,
    input  logic                       s_valid_i,
    input  logic [`PBCH_SAMPLE_DW-1:0] s_data_i,
    output logic                       dmrs_ready_o,
    output pbch_pkg::ibar_t            ibar_o,
    output logic                       ibar_valid_o
);
    import pbch_pkg::*;

    logic       [1:0] start_idx;
    corr_vec_t        corr;
    corr_vec_t        corr_rot;
    logic             corr_done;

    dmrs_table_if tbl_if ();

    dmrs_generator dmrs_generator_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .n_id_i       (n_id_i),
        .n_id_valid_i (n_id_valid_i),
        .dmrs_ready_o (dmrs_ready_o),
        .start_idx_o  (start_idx),
        .tbl          (tbl_if.gen)
    );

    dmrs_table dmrs_table_i (
        .clk_i (clk_i),
        .tbl   (tbl_if.mem)
    );

    dmrs_correlator dmrs_correlator_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .s_valid_i    (s_valid_i),
        .s_data_i     (sample_t'(s_data_i)),
        .pbch_start_i (pbch_start_i),
        .dmrs_ready_i (dmrs_ready_o),
        .start_idx_i  (start_idx),
        .corr_o       (corr),
        .corr_rot_o   (corr_rot),
        .corr_done_o  (corr_done),
        .tbl          (tbl_if.corr)
    );

    ibar_selector ibar_selector_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .corr_i       (corr),
        .corr_rot_i   (corr_rot),
        .corr_done_i  (corr_done),
        .ibar_o       (ibar_o),
        .ibar_valid_o (ibar_valid_o)
    );

endmodule

/* pbch_pkg.sv */
`include "pbch_consts.svh"

package pbch_pkg;

    // im sits in the upper half of the word, re in the lower half
    typedef struct packed {
        logic signed [`PBCH_SAMPLE_DW/2-1:0] im;
        logic signed [`PBCH_SAMPLE_DW/2-1:0] re;
    } sample_t;

    // bit 1 holds c(2k), bit 0 holds c(2k+1)
    typedef logic [1:0] dmrs_sym_t;

    // symbol k of all candidates, candidate i at index i
    typedef dmrs_sym_t [`PBCH_NUM_IBAR-1:0] dmrs_row_t;

    typedef logic [$clog2(`PBCH_DMRS_LEN)-1:0] dmrs_addr_t;

    // cell identities run from 0 to 1007
    typedef logic [9:0] n_id_t;

    typedef logic [$clog2(`PBCH_NUM_IBAR)-1:0] ibar_t;

    // one symbol has 64 pilots with two bits each, so the sum stays within +-128
    typedef logic signed [8:0] corr_t;

    typedef corr_t [`PBCH_NUM_IBAR-1:0] corr_vec_t;

endpackage

/* pn_lfsr.sv */
`timescale 1ns/1ps
`include "pbch_consts.svh"

module pn_lfsr #(
    // bit k set means x(n+k) takes part in the feedback
    parameter logic [`PBCH_LFSR_LEN-1:0] TAPS = 'h9
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      load_i,
    input  logic                      step_i,
    input  logic [`PBCH_LFSR_LEN-1:0] seed_i,
    output logic                      bit_o
);

    // state_q[k] holds x(n+k), so bit 0 is the oldest bit
    logic [`PBCH_LFSR_LEN-1:0] state_q;
    logic                      feedback;

    assign feedback = ^(state_q & TAPS);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= '0;
        end else if (load_i) begin
            state_q <= seed_i;
        end else if (step_i) begin
            // the new bit x(n+31) enters at the top
            state_q <= {feedback, state_q[`PBCH_LFSR_LEN-1:1]};
        end
    end

    assign bit_o = state_q[0];

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset is released on a rising edge, like every other stimulus
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_no <= 1'b1;
    end

endmodule

/* tb_pbch_dmrs_detect.sv */
`timescale 1ns/1ps
`include "pbch_consts.svh"

module tb_pbch_dmrs_detect;
    import pbch_pkg::*;

    localparam int SEQ_LEN      = `PBCH_SKIP_BITS + 2 * `PBCH_DMRS_LEN;
    localparam int READY_CYCLES = 1890;
    localparam logic signed [15:0] PILOT_AMP = 16'sd1000;

    logic        clk;
    logic        reset_n;
    n_id_t       n_id;
    logic        n_id_valid;
    logic        pbch_start;
    logic        s_valid;
    logic [31:0] s_data;
    logic        dmrs_ready;
    ibar_t       ibar;
    logic        ibar_valid;
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          load_cycle;

    tb_clock_gen clock_gen_i (
        .clk_o    (clk),
        .reset_no (reset_n)
    );

    pbch_dmrs_detect_top pbch_dmrs_detect_top_i (
        .clk_i        (clk),
        .reset_ni     (reset_n),
        .n_id_i       (n_id),
        .n_id_valid_i (n_id_valid),
        .pbch_start_i (pbch_start),
        .s_valid_i    (s_valid),
        .s_data_i     (s_data),
        .dmrs_ready_o (dmrs_ready),
        .ibar_o       (ibar),
        .ibar_valid_o (ibar_valid)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        stop_on_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    always @(negedge clk) begin
        if (pbch_dmrs_detect_top_i.pbch_dmrs_detect_sva_i.any_fail) begin
            stop_on_error("a protocol assertion on the DUT failed");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // the upper bits of the generator are the better mixed ones
    function automatic int rand_below(input int limit);
        return int'((lcg_next() >> 8) % 32'(limit));
    endfunction

    // bit n of the result is c(n) of candidate ibar_v, counted after the skipped bits
    function automatic logic [2*`PBCH_DMRS_LEN-1:0] dmrs_bits(input int n_id_v,
                                                             input int ibar_v);
        logic                        x1 [0:SEQ_LEN-1];
        logic                        x2 [0:SEQ_LEN-1];
        logic [30:0]                 c_init;
        logic [2*`PBCH_DMRS_LEN-1:0] bits;
        c_init = 31'((ibar_v + 1) * (n_id_v / 4 + 1) * 2048 + (ibar_v + 1) * 64 + n_id_v % 4);
        for (int n = 0; n < 31; n++) begin
            x1[n] = (n == 0);
            x2[n] = c_init[n];
        end
        for (int n = 0; n + 31 < SEQ_LEN; n++) begin
            x1[n+31] = x1[n+3] ^ x1[n];
            x2[n+31] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
        end
        for (int n = 0; n < 2 * `PBCH_DMRS_LEN; n++) begin
            bits[n] = x1[n+`PBCH_SKIP_BITS] ^ x2[n+`PBCH_SKIP_BITS];
        end
        return bits;
    endfunction

    task automatic check_idle_outputs();
        assert (dmrs_ready == 1'b0) else value_mismatch("dmrs_ready_o", 32'(dmrs_ready), 0);
        assert (ibar_valid == 1'b0) else value_mismatch("ibar_valid_o", 32'(ibar_valid), 0);
        assert (ibar == '0) else value_mismatch("ibar_o", 32'(ibar), 0);
    endtask

    task automatic load_n_id(input int n_id_v);
        @(posedge clk);
        n_id       <= n_id_t'(n_id_v);
        n_id_valid <= 1'b1;
        @(posedge clk);
        n_id_valid <= 1'b0;
        load_cycle = cycle_cnt;
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!dmrs_ready) begin
            if (waited >= 2 * READY_CYCLES) begin
                stop_on_error("dmrs_ready_o never rose after a new cell identity");
            end
            @(negedge clk);
            waited++;
        end
        assert (cycle_cnt - load_cycle <= READY_CYCLES)
            else value_mismatch("dmrs_ready_o delay", cycle_cnt - load_cycle, READY_CYCLES);
    endtask

    // mode 0 sends the symbol as is, mode 1 turns it by 90 degrees, mode 2 by 180
    task automatic send_symbol(input int n_id_v, input int ibar_v, input int mode,
                               input bit gaps);
        logic [2*`PBCH_DMRS_LEN-1:0] bits;
        logic signed [15:0]          re;
        logic signed [15:0]          im;
        logic signed [15:0]          tmp;
        logic [31:0]                 r;
        int                          sc;
        int                          k;
        int                          guard;
        bits  = dmrs_bits(n_id_v, ibar_v);
        sc    = 0;
        guard = 0;
        @(posedge clk);
        pbch_start <= 1'b1;
        @(posedge clk);
        pbch_start <= 1'b0;
        while (sc < `PBCH_FFT_LEN) begin
            r = lcg_next();
            if (gaps && r[31:30] == 2'd0) begin
                s_valid <= 1'b0;
            end else begin
                if (sc % `PBCH_PILOT_SPACING == n_id_v % 4) begin
                    k  = sc / `PBCH_PILOT_SPACING;
                    re = bits[2*k] ? -PILOT_AMP : PILOT_AMP;
                    im = bits[2*k+1] ? -PILOT_AMP : PILOT_AMP;
                end else begin
                    re = r[23:8];
                    r  = lcg_next();
                    im = r[23:8];
                end
                case (mode)
                    1: begin
                        tmp = re;
                        re  = -im;
                        im  = tmp;
                    end
                    2: begin
                        re = -re;
                        im = -im;
                    end
                    default: ;
                endcase
                s_valid <= 1'b1;
                s_data  <= {im, re};
                sc++;
            end
            guard++;
            if (guard > 4 * `PBCH_FFT_LEN) begin
                stop_on_error("the sample stream did not finish the symbol");
            end
            @(posedge clk);
        end
        s_valid <= 1'b0;
    endtask

    // called right after the edge that takes the last sample
    task automatic expect_result(input int ibar_v);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ibar_valid) begin
            if (waited >= 16) begin
                stop_on_error("no ibar_valid_o pulse after the last sample");
            end
            @(negedge clk);
            waited++;
        end
        assert (waited == 2) else value_mismatch("ibar_valid_o latency", waited, 2);
        assert (ibar == ibar_t'(ibar_v)) else value_mismatch("ibar_o", 32'(ibar), ibar_v);
    endtask

    task automatic expect_no_result(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (!ibar_valid) else value_mismatch("ibar_valid_o", 32'(ibar_valid), 0);
        end
    endtask

    initial begin
        int n;
        int b;
        int guard;
        n_id       = '0;
        n_id_valid = 1'b0;
        pbch_start = 1'b0;
        s_valid    = 1'b0;
        s_data     = '0;
        lcg_state  = 32'hd170fa8b;
        guard      = 0;

        @(posedge clk);
        do begin
            @(negedge clk);
            check_idle_outputs();
            guard++;
            if (guard > 16) begin
                stop_on_error("reset was never released");
            end
        end while (!reset_n);
        @(negedge clk);
        check_idle_outputs();

        // a symbol sent while the candidates are still being built is ignored
        n = rand_below(1008);
        load_n_id(n);
        send_symbol(n, 0, 0, 1'b0);
        expect_no_result(8);
        wait_ready();

        for (int i = 0; i < 4; i++) begin
            if (i > 0) begin
                n = rand_below(1008);
                load_n_id(n);
                wait_ready();
            end
            b = rand_below(8);
            send_symbol(n, b, 0, 1'b0);
            expect_result(b);
        end

        for (int mode = 1; mode < 3; mode++) begin
            b = rand_below(8);
            send_symbol(n, b, mode, 1'b0);
            expect_result(b);
        end

        for (int mode = 0; mode < 2; mode++) begin
            b = rand_below(8);
            send_symbol(n, b, mode, 1'b1);
            expect_result(b);
        end

        // a second cell identity in the middle of generation wins
        load_n_id(rand_below(1008));
        repeat (rand_below(1500) + 50) @(posedge clk);
        n = rand_below(1008);
        load_n_id(n);
        wait_ready();
        b = rand_below(8);
        send_symbol(n, b, 0, 1'b1);
        expect_result(b);

        if (pbch_dmrs_detect_top_i.pbch_dmrs_detect_sva_i.any_fail) begin
            stop_on_error("a protocol assertion on the DUT failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
